// File: logic/biu_bridge_pkg.sv
////////////////////////////////////////
// BIU bridge types
// Burst and size codes plus the packed
// payloads that move between stages
////////////////////////////////////////

`include "spram_bridge_settings.svh"

package biu_bridge_pkg;

  // Burst codes in AHB order
  typedef enum logic [2:0] {
    BURST_SINGLE = 3'd0,
    BURST_INCR   = 3'd1,
    BURST_WRAP4  = 3'd2,
    BURST_INCR4  = 3'd3,
    BURST_WRAP8  = 3'd4,
    BURST_INCR8  = 3'd5,
    BURST_WRAP16 = 3'd6,
    BURST_INCR16 = 3'd7
  } biu_burst_e;

  // Transfer size, codes 4..7 illegal on a 64-bit path
  typedef enum logic [2:0] {
    SIZE_BYTE  = 3'd0,
    SIZE_HALF  = 3'd1,
    SIZE_WORD  = 3'd2,
    SIZE_DWORD = 3'd3
  } biu_size_e;

  ////////////////////////////////////////
  // Channel payloads
  ////////////////////////////////////////

  // Request from the core
  typedef struct packed {
    logic [`SB_PLEN-1:0] addr;
    biu_size_e           size;
    biu_burst_e          burst;
    logic                we;
  } biu_req_t;

  // One word of write data
  typedef struct packed {
    logic [`SB_XLEN-1:0] data;
  } biu_wdata_t;

  // Decoded command, wrap_mask keeps the bits above the wrap block
  typedef struct packed {
    biu_req_t            req;
    logic [3:0]          beats_m1;
    logic [`SB_PLEN-1:0] wrap_mask;
    logic                err;
  } biu_cmd_t;

  // One RAM beat
  typedef struct packed {
    logic [`SB_PLEN-1:0]   addr;
    logic                  we;
    logic [`SB_XLEN/8-1:0] be;
    logic [`SB_XLEN-1:0]   wdata;
    logic                  err;
    logic                  last;
  } biu_beat_t;

  // One response per beat
  typedef struct packed {
    logic [`SB_PLEN-1:0] addr;
    logic [`SB_XLEN-1:0] rdata;
    logic                we;
    logic                err;
    logic                last;
  } biu_rsp_t;

endpackage

// File: logic/biu_cmd_decode.sv
////////////////////////////////////////
// BIU command decode
// First stage: size check, beat count,
// wrap mask and error flag per request
////////////////////////////////////////

`timescale 1ns/1ps
`include "spram_bridge_settings.svh"

module biu_cmd_decode (
  input  logic                     clk,
  input  logic                     rst,

  // Request in
  input  logic                     req_valid_i,
  output logic                     req_ready_o,
  input  biu_bridge_pkg::biu_req_t req_i,

  // Decoded command out
  output logic                     cmd_valid_o,
  input  logic                     cmd_ready_i,
  output biu_bridge_pkg::biu_cmd_t cmd_o
);

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  biu_bridge_pkg::biu_cmd_t cmd_d;
  logic                     req_fire;
  logic                     is_wrap;

  // Burst code to beats minus one
  function automatic logic [3:0] burst_beats_m1(input biu_bridge_pkg::biu_burst_e burst);
    case (burst)
      biu_bridge_pkg::BURST_WRAP4,
      biu_bridge_pkg::BURST_INCR4:  return 4'd3;
      biu_bridge_pkg::BURST_WRAP8,
      biu_bridge_pkg::BURST_INCR8:  return 4'd7;
      biu_bridge_pkg::BURST_WRAP16,
      biu_bridge_pkg::BURST_INCR16: return 4'd15;
      // SINGLE, and INCR of undefined length
      default:                      return 4'd0;
    endcase
  endfunction

  assign is_wrap = (req_i.burst == biu_bridge_pkg::BURST_WRAP4) ||
                   (req_i.burst == biu_bridge_pkg::BURST_WRAP8) ||
                   (req_i.burst == biu_bridge_pkg::BURST_WRAP16);

  always_comb begin
    cmd_d          = '0;
    cmd_d.req      = req_i;
    // Wider than a doubleword does not fit the data path
    cmd_d.err      = (req_i.size > biu_bridge_pkg::SIZE_DWORD);
    cmd_d.beats_m1 = burst_beats_m1(req_i.burst);
    // Block is beats x 8 bytes, keep everything above it
    if (is_wrap) begin
      cmd_d.wrap_mask = {{(`SB_PLEN-7){1'b1}}, ~{cmd_d.beats_m1, 3'b111}};
    end
    // Error collapses to one beat, no wrapping
    if (cmd_d.err) begin
      cmd_d.beats_m1  = 4'd0;
      cmd_d.wrap_mask = '0;
    end
  end

  ////////////////////////////////////////
  // Output register
  ////////////////////////////////////////

  // Free slot, or the held command leaves this cycle
  assign req_ready_o = ~cmd_valid_o | cmd_ready_i;
  assign req_fire    = req_valid_i & req_ready_o;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      cmd_valid_o <= 1'b0;
    end else if (req_fire) begin
      cmd_valid_o <= 1'b1;
    end else if (cmd_ready_i) begin
      cmd_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) cmd_o <= cmd_d;
  end

endmodule

// File: logic/burst_addr_gen.sv
////////////////////////////////////////
// Burst address generator
// Second stage: expands a command into
// beats and joins write data per beat
////////////////////////////////////////

`timescale 1ns/1ps
`include "spram_bridge_settings.svh"

module burst_addr_gen (
  input  logic                       clk,
  input  logic                       rst,

  // Decoded command
  input  logic                       cmd_valid_i,
  output logic                       cmd_ready_o,
  input  biu_bridge_pkg::biu_cmd_t   cmd_i,

  // Write data, one word per write beat
  input  logic                       wd_valid_i,
  output logic                       wd_ready_o,
  input  biu_bridge_pkg::biu_wdata_t wd_i,

  // Beats to the RAM stage
  output logic                       beat_valid_o,
  input  logic                       beat_ready_i,
  output biu_bridge_pkg::biu_beat_t  beat_o
);

  biu_bridge_pkg::biu_cmd_t cmd_q;
  logic [`SB_PLEN-1:0]      addr_q;
  logic [3:0]               cnt_q;
  logic                     busy_q;
  logic                     need_wd;
  logic                     cmd_fire;
  logic                     beat_fire;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // Align down to 8 bytes, step one word, then fold into the wrap block
  function automatic logic [`SB_PLEN-1:0] next_addr(input logic [`SB_PLEN-1:0] addr,
                                                    input logic [`SB_PLEN-1:0] keep);
    logic [`SB_PLEN-1:0] lin;
    lin = {addr[`SB_PLEN-1:3] + 1'b1, 3'b000};
    return (addr & keep) | (lin & ~keep);
  endfunction

  // Lanes by size, starting at the aligned lane
  function automatic logic [`SB_XLEN/8-1:0] byte_en(input biu_bridge_pkg::biu_size_e size,
                                                    input logic [2:0] lo);
    case (size)
      biu_bridge_pkg::SIZE_BYTE: return 8'h01 << lo;
      biu_bridge_pkg::SIZE_HALF: return 8'h03 << {lo[2:1], 1'b0};
      biu_bridge_pkg::SIZE_WORD: return 8'h0f << {lo[2], 2'b00};
      default:                   return 8'hff;
    endcase
  endfunction

  ////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////

  // Error beats never take write data
  assign need_wd = cmd_q.req.we & ~cmd_q.err;

  // New command only once the last beat has left
  assign cmd_ready_o  = ~busy_q;
  assign cmd_fire     = cmd_valid_i & cmd_ready_o;
  assign beat_valid_o = busy_q & (~need_wd | wd_valid_i);
  assign beat_fire    = beat_valid_o & beat_ready_i;
  // Data word moves together with its beat
  assign wd_ready_o   = busy_q & need_wd & beat_ready_i;

  always_comb begin
    beat_o       = '0;
    beat_o.addr  = addr_q;
    beat_o.we    = cmd_q.req.we;
    beat_o.be    = cmd_q.err ? '0 : byte_en(cmd_q.req.size, addr_q[2:0]);
    beat_o.wdata = wd_i.data;
    beat_o.err   = cmd_q.err;
    beat_o.last  = (cnt_q == 4'd0);
  end

  ////////////////////////////////////////
  // Beat counter and address
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      busy_q <= 1'b0;
      cnt_q  <= 4'd0;
    end else if (cmd_fire) begin
      busy_q <= 1'b1;
      cnt_q  <= cmd_i.beats_m1;
    end else if (beat_fire) begin
      if (cnt_q == 4'd0) busy_q <= 1'b0;
      else cnt_q <= cnt_q - 4'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_fire) begin
      cmd_q  <= cmd_i;
      addr_q <= cmd_i.req.addr;
    end else if (beat_fire) begin
      addr_q <= next_addr(addr_q, cmd_q.wrap_mask);
    end
  end

  // Counter steps down by one per beat and never wraps below zero
  a_cnt_step : assert property (@(posedge clk) disable iff (!rst)
    beat_fire && !beat_o.last |=> busy_q && cnt_q == $past(cnt_q) - 4'd1);
  a_last_idle : assert property (@(posedge clk) disable iff (!rst)
    beat_fire && beat_o.last |=> !busy_q);

endmodule

// File: logic/skid_buffer.sv
////////////////////////////////////////
// Skid buffer
// Two-entry valid/ready stage for any
// payload type, ready from occupancy only
////////////////////////////////////////

`timescale 1ns/1ps

module skid_buffer #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic rst,

  // Upstream side
  input  logic in_valid_i,
  output logic in_ready_o,
  input  T     in_data_i,

  // Downstream side
  output logic out_valid_o,
  input  logic out_ready_i,
  output T     out_data_o
);

  // Entry storage, no reset needed for payload
  T           entry_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic       push;
  logic       pop;

  // Second entry catches the beat in flight when ready drops
  assign in_ready_o  = (count_q != 2'd2);
  assign out_valid_o = (count_q != 2'd0);
  assign out_data_o  = entry_q[rd_ptr_q];

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  // Pointers and occupancy
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) wr_ptr_q <= ~wr_ptr_q;
      if (pop) rd_ptr_q <= ~rd_ptr_q;
      count_q <= count_q + {1'b0, push} - {1'b0, pop};
    end
  end

  always_ff @(posedge clk) begin
    if (push) entry_q[wr_ptr_q] <= in_data_i;
  end

  // Stalled output must hold its payload
  a_hold_stable : assert property (@(posedge clk) disable iff (!rst)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o));

endmodule

// File: logic/spram_access_stage.sv
////////////////////////////////////////
// SPRAM access stage
// Third stage: drives the RAM per beat
// and pairs read data with beat info
////////////////////////////////////////

`timescale 1ns/1ps
`include "spram_bridge_settings.svh"

module spram_access_stage #(
  parameter int AW = $clog2(`SB_RAM_WORDS)
) (
  input  logic                      clk,
  input  logic                      rst,

  // Beats in
  input  logic                      beat_valid_i,
  output logic                      beat_ready_o,
  input  biu_bridge_pkg::biu_beat_t beat_i,

  // RAM port
  output logic                      ram_en_o,
  output logic                      ram_we_o,
  output logic [`SB_XLEN/8-1:0]     ram_be_o,
  output logic [AW-1:0]             ram_addr_o,
  output logic [`SB_XLEN-1:0]       ram_wdata_o,
  input  logic [`SB_XLEN-1:0]       ram_rdata_i,

  // Responses out
  output logic                      rsp_valid_o,
  input  logic                      rsp_ready_i,
  output biu_bridge_pkg::biu_rsp_t  rsp_o
);

  logic                accept;
  logic [`SB_PLEN-1:0] addr_q;
  logic                we_q;
  logic                err_q;
  logic                last_q;

  // Slot free or draining; a held slot keeps RAM idle so rdata stays put
  assign beat_ready_o = ~rsp_valid_o | rsp_ready_i;
  assign accept       = beat_valid_i & beat_ready_o;

  ////////////////////////////////////////
  // RAM drive
  ////////////////////////////////////////

  assign ram_en_o    = accept & ~beat_i.err;
  assign ram_we_o    = beat_i.we;
  assign ram_be_o    = beat_i.be;
  // Word index, wraps at RAM depth
  assign ram_addr_o  = beat_i.addr[AW+2:3];
  assign ram_wdata_o = beat_i.wdata;

  ////////////////////////////////////////
  // Response slot
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      rsp_valid_o <= 1'b0;
    end else if (accept) begin
      rsp_valid_o <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q <= beat_i.addr;
      we_q   <= beat_i.we;
      err_q  <= beat_i.err;
      last_q <= beat_i.last;
    end
  end

  // Read data only for good reads
  always_comb begin
    rsp_o       = '0;
    rsp_o.addr  = addr_q;
    rsp_o.rdata = (we_q | err_q) ? '0 : ram_rdata_i;
    rsp_o.we    = we_q;
    rsp_o.err   = err_q;
    rsp_o.last  = last_q;
  end

  // Error beat arrives with no byte lanes and never reaches the RAM
  a_err_no_ram : assert property (@(posedge clk) disable iff (!rst)
    beat_valid_i && beat_i.err |-> !ram_en_o && beat_i.be == '0);

endmodule

// File: logic/spram_array.sv
////////////////////////////////////////
// Single-port RAM
// Byte-lane writes, registered read one
// cycle after enable
////////////////////////////////////////

`timescale 1ns/1ps
`include "spram_bridge_settings.svh"

module spram_array #(
  parameter int DEPTH = `SB_RAM_WORDS,
  parameter int AW    = $clog2(DEPTH)
) (
  input  logic                   clk,

  // Access port
  input  logic                   en_i,
  input  logic                   we_i,
  input  logic [`SB_XLEN/8-1:0]  be_i,
  input  logic [AW-1:0]          addr_i,
  input  logic [`SB_XLEN-1:0]    wdata_i,
  output logic [`SB_XLEN-1:0]    rdata_o
);

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  logic [`SB_XLEN-1:0] mem [DEPTH];

  // Lane writes
  always_ff @(posedge clk) begin
    if (en_i && we_i) begin
      for (int lane = 0; lane < `SB_XLEN/8; lane++) begin
        if (be_i[lane]) mem[addr_i][lane*8 +: 8] <= wdata_i[lane*8 +: 8];
      end
    end
  end

  // Read first, old word on a write
  // Output holds while en_i stays low
  always_ff @(posedge clk) begin
    if (en_i) rdata_o <= mem[addr_i];
  end

endmodule

// File: logic/spram_bridge_settings.svh
////////////////////////////////////////
// SPRAM bridge build settings
// Data path, byte address and RAM depth
// shared by the package and the RTL
////////////////////////////////////////

`ifndef SPRAM_BRIDGE_SETTINGS_SVH
`define SPRAM_BRIDGE_SETTINGS_SVH

////////////////////////////////////////
// Widths
////////////////////////////////////////

// Data path, one 64-bit word per beat
`define SB_XLEN 64

// Byte address width on the core side
`define SB_PLEN 32

// RAM depth in words, power of two
`define SB_RAM_WORDS 256

`endif

// File: logic/spram_bridge_top.sv
////////////////////////////////////////
// SPRAM bridge top
// Request skid, decode, address gen,
// RAM access and response skid
////////////////////////////////////////

`timescale 1ns/1ps
`include "spram_bridge_settings.svh"

module spram_bridge_top (
  input  logic                       clk,
  input  logic                       rst,

  // Request channel
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  input  biu_bridge_pkg::biu_req_t   req_i,

  // Write-data channel
  input  logic                       wd_valid_i,
  output logic                       wd_ready_o,
  input  biu_bridge_pkg::biu_wdata_t wd_i,

  // Response channel
  output logic                       rsp_valid_o,
  input  logic                       rsp_ready_i,
  output biu_bridge_pkg::biu_rsp_t   rsp_o
);

  localparam int AW = $clog2(`SB_RAM_WORDS);

  ////////////////////////////////////////
  // Stage links
  ////////////////////////////////////////

  logic                      sreq_valid;
  logic                      sreq_ready;
  biu_bridge_pkg::biu_req_t  sreq;
  logic                      cmd_valid;
  logic                      cmd_ready;
  biu_bridge_pkg::biu_cmd_t  cmd;
  logic                      beat_valid;
  logic                      beat_ready;
  biu_bridge_pkg::biu_beat_t beat;
  logic                      arsp_valid;
  logic                      arsp_ready;
  biu_bridge_pkg::biu_rsp_t  arsp;

  // RAM port
  logic                      ram_en;
  logic                      ram_we;
  logic [`SB_XLEN/8-1:0]     ram_be;
  logic [AW-1:0]             ram_addr;
  logic [`SB_XLEN-1:0]       ram_wdata;
  logic [`SB_XLEN-1:0]       ram_rdata;

  skid_buffer #(.T(biu_bridge_pkg::biu_req_t)) i_req_skid (
    .clk, .rst,
    .in_valid_i (req_valid_i), .in_ready_o (req_ready_o), .in_data_i (req_i),
    .out_valid_o(sreq_valid),  .out_ready_i(sreq_ready),  .out_data_o(sreq)
  );

  biu_cmd_decode i_cmd_decode (
    .clk, .rst,
    .req_valid_i(sreq_valid), .req_ready_o(sreq_ready), .req_i(sreq),
    .cmd_valid_o(cmd_valid),  .cmd_ready_i(cmd_ready),  .cmd_o(cmd)
  );

  burst_addr_gen i_burst_addr_gen (
    .clk, .rst,
    .cmd_valid_i (cmd_valid),  .cmd_ready_o (cmd_ready),  .cmd_i (cmd),
    .wd_valid_i  (wd_valid_i), .wd_ready_o  (wd_ready_o), .wd_i  (wd_i),
    .beat_valid_o(beat_valid), .beat_ready_i(beat_ready), .beat_o(beat)
  );

  spram_access_stage #(.AW(AW)) i_access_stage (
    .clk, .rst,
    .beat_valid_i(beat_valid), .beat_ready_o(beat_ready), .beat_i(beat),
    .ram_en_o    (ram_en),     .ram_we_o    (ram_we),     .ram_be_o(ram_be),
    .ram_addr_o  (ram_addr),   .ram_wdata_o (ram_wdata),  .ram_rdata_i(ram_rdata),
    .rsp_valid_o (arsp_valid), .rsp_ready_i (arsp_ready), .rsp_o(arsp)
  );

  spram_array #(.DEPTH(`SB_RAM_WORDS), .AW(AW)) i_spram (
    .clk,
    .en_i(ram_en), .we_i(ram_we), .be_i(ram_be), .addr_i(ram_addr),
    .wdata_i(ram_wdata), .rdata_o(ram_rdata)
  );

  skid_buffer #(.T(biu_bridge_pkg::biu_rsp_t)) i_rsp_skid (
    .clk, .rst,
    .in_valid_i (arsp_valid),  .in_ready_o (arsp_ready),  .in_data_i (arsp),
    .out_valid_o(rsp_valid_o), .out_ready_i(rsp_ready_i), .out_data_o(rsp_o)
  );

endmodule

// File: test/tb_spram_bridge.sv
////////////////////////////////////////
// SPRAM bridge testbench
// Random bursts against a byte-wise
// reference memory, checked by assertions
////////////////////////////////////////

`timescale 1ns/1ps
`include "spram_bridge_settings.svh"

module tb_spram_bridge;

  localparam int HS_TIMEOUT    = 200;
  localparam int DRAIN_TIMEOUT = 5000;
  localparam int ADDR_SPAN     = `SB_RAM_WORDS * 16;

  logic                       clk;
  logic                       rst;
  logic                       req_valid_i;
  logic                       req_ready_o;
  biu_bridge_pkg::biu_req_t   req_i;
  logic                       wd_valid_i;
  logic                       wd_ready_o;
  biu_bridge_pkg::biu_wdata_t wd_i;
  logic                       rsp_valid_o;
  logic                       rsp_ready_i;
  biu_bridge_pkg::biu_rsp_t   rsp_o;

  // Reference memory and scoreboard
  logic [7:0]               ref_mem [`SB_RAM_WORDS*8];
  biu_bridge_pkg::biu_rsp_t exp_q [$];
  logic [`SB_XLEN-1:0]      wd_q [$];
  biu_bridge_pkg::biu_rsp_t head_rsp;
  logic                     head_ok;
  logic                     wd_fire;
  logic                     bp_mode;
  int                       cyc = 0;
  int                       errors;
  int                       err_mark;
  int                       tests_run;
  int                       tests_clean;
  int                       rsp_seen;

  spram_bridge_top i_spram_bridge_top (
    .clk, .rst,
    .req_valid_i, .req_ready_o, .req_i,
    .wd_valid_i, .wd_ready_o, .wd_i,
    .rsp_valid_o, .rsp_ready_i, .rsp_o
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  ////////////////////////////////////////
  // Reporting and reference model
  ////////////////////////////////////////

  function automatic void flag_value(input string name, input logic [63:0] got,
                                     input logic [63:0] exp);
    errors++;
    $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
  endfunction

  function automatic void note_failure(input string why);
    errors++;
    $display("%0t: %s", $time, why);
  endfunction

  task automatic abort_run(input string why);
    $display("timeout: %s", why);
    $display("test failed");
    $finish;
  endtask

  // RAM word index wraps at the depth
  function automatic int word_idx(input logic [`SB_PLEN-1:0] a);
    return int'((a >> 3) % `SB_RAM_WORDS);
  endfunction

  // Lanes start at the address aligned down to the transfer size
  function automatic void ref_store(input logic [31:0] a, input logic [2:0] size,
                                    input logic [63:0] d);
    int lanes;
    int first;
    lanes = 1 << size;
    first = int'(a[2:0]) & ~(lanes - 1);
    for (int l = first; l < first + lanes; l++) begin
      ref_mem[word_idx(a)*8 + l] = d[l*8 +: 8];
    end
  endfunction

  function automatic logic [63:0] ref_load(input logic [31:0] a);
    logic [63:0] w;
    for (int l = 0; l < 8; l++) begin
      w[l*8 +: 8] = ref_mem[word_idx(a)*8 + l];
    end
    return w;
  endfunction

  function automatic int beats_of(input logic [2:0] burst);
    case (burst)
      3'd2, 3'd3: return 4;
      3'd4, 3'd5: return 8;
      3'd6, 3'd7: return 16;
      default:    return 1;
    endcase
  endfunction

  // Align, step 8 bytes, wrap bursts keep the bits above the block
  function automatic logic [31:0] step_addr(input logic [31:0] a, input logic [2:0] burst,
                                            input int n);
    logic [31:0] lin;
    logic [31:0] blk;
    lin = (a & ~32'h7) + 32'd8;
    blk = n * 8;
    if (burst == 3'd2 || burst == 3'd4 || burst == 3'd6) begin
      return (a & ~(blk - 1)) | (lin & (blk - 1));
    end
    return lin;
  endfunction

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // Predict every beat, queue write data, then hand the request over
  task automatic issue(input logic [31:0] addr, input logic [2:0] size,
                       input logic [2:0] burst, input logic we);
    biu_bridge_pkg::biu_rsp_t e;
    logic [31:0]              a;
    logic [63:0]              d;
    int                       n;
    int                       waited;
    n = (size > 3'd3) ? 1 : beats_of(burst);
    a = addr;
    for (int i = 0; i < n; i++) begin
      e      = '0;
      e.addr = a;
      e.we   = we;
      e.err  = (size > 3'd3);
      e.last = (i == n - 1);
      if (size <= 3'd3 && we) begin
        d = {$urandom, $urandom};
        wd_q.push_back(d);
        ref_store(a, size, d);
      end else if (size <= 3'd3) begin
        e.rdata = ref_load(a);
      end
      exp_q.push_back(e);
      a = step_addr(a, burst, n);
    end
    req_i       = {addr, size, burst, we};
    req_valid_i = 1'b1;
    waited      = 0;
    // Ready depends on state only, stable from here to the next edge
    while (!req_ready_o) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > HS_TIMEOUT) abort_run("request handshake did not complete");
    end
    @(posedge clk);
    #1;
    req_valid_i = 1'b0;
  endtask

  // Wait for the scoreboard to empty, then log the test
  task automatic close_test(input string name);
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > DRAIN_TIMEOUT) abort_run("expected responses never arrived");
    end
    repeat (2) @(posedge clk);
    #1;
    tests_run++;
    if (errors == err_mark) tests_clean++;
    $display("%-16s %0d errors", name, errors - err_mark);
    err_mark = errors;
  endtask

  // Transfers are settled half a cycle before the edge that takes them
  always @(negedge clk) begin
    wd_fire = wd_valid_i && wd_ready_o;
    if (rst && rsp_valid_o && rsp_ready_i) begin
      rsp_seen++;
      head_ok = (exp_q.size() != 0);
      if (head_ok) head_rsp = exp_q.pop_front();
    end
  end

  // Write data and response ready, random only under back-pressure
  initial begin
    forever begin
      @(posedge clk);
      #1;
      if (wd_fire) wd_q.delete(0);
      // Valid stays up until its word is taken
      if (!wd_valid_i || wd_fire) begin
        wd_valid_i = (wd_q.size() != 0) && (!bp_mode || $urandom_range(1, 0) == 1);
        wd_i.data  = (wd_q.size() != 0) ? wd_q[0] : '0;
      end
      rsp_ready_i = !bp_mode || ($urandom_range(2, 0) != 0);
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  a_reset_idle : assert property (@(posedge clk)
    cyc >= 1 && cyc <= 10 |-> !rsp_valid_o && req_ready_o)
    else note_failure("outputs not idle during or right after reset");

  a_rsp_expected : assert property (@(posedge clk) disable iff (!rst)
    rsp_valid_o && rsp_ready_i |-> head_ok)
    else note_failure("response arrived with no response expected");

  a_rsp_addr : assert property (@(posedge clk) disable iff (!rst)
    rsp_valid_o && rsp_ready_i && head_ok |-> rsp_o.addr == head_rsp.addr)
    else flag_value("rsp_o.addr", $sampled(rsp_o.addr), $sampled(head_rsp.addr));

  a_rsp_rdata : assert property (@(posedge clk) disable iff (!rst)
    rsp_valid_o && rsp_ready_i && head_ok |-> rsp_o.rdata == head_rsp.rdata)
    else flag_value("rsp_o.rdata", $sampled(rsp_o.rdata), $sampled(head_rsp.rdata));

  a_rsp_we : assert property (@(posedge clk) disable iff (!rst)
    rsp_valid_o && rsp_ready_i && head_ok |-> rsp_o.we == head_rsp.we)
    else flag_value("rsp_o.we", $sampled(rsp_o.we), $sampled(head_rsp.we));

  a_rsp_err : assert property (@(posedge clk) disable iff (!rst)
    rsp_valid_o && rsp_ready_i && head_ok |-> rsp_o.err == head_rsp.err)
    else flag_value("rsp_o.err", $sampled(rsp_o.err), $sampled(head_rsp.err));

  a_rsp_last : assert property (@(posedge clk) disable iff (!rst)
    rsp_valid_o && rsp_ready_i && head_ok |-> rsp_o.last == head_rsp.last)
    else flag_value("rsp_o.last", $sampled(rsp_o.last), $sampled(head_rsp.last));

  // Stalled response must not move
  a_rsp_hold : assert property (@(posedge clk) disable iff (!rst)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o))
    else note_failure("rsp_o changed or dropped while waiting for ready");

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    logic [31:0] a;
    logic [2:0]  s;
    logic [2:0]  b;
    logic [2:0]  kinds [3];
    int          n;
    void'($urandom(29692));
    rst         = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    wd_valid_i  = 1'b0;
    wd_i        = '0;
    rsp_ready_i = 1'b1;
    bp_mode     = 1'b0;
    head_ok     = 1'b0;
    head_rsp    = '0;
    wd_fire     = 1'b0;
    errors      = 0;
    err_mark    = 0;
    tests_run   = 0;
    tests_clean = 0;
    rsp_seen    = 0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    close_test("reset");

    // Known contents everywhere before any read
    for (int w = 0; w < `SB_RAM_WORDS; w += 16) begin
      issue(w * 8, 3'd3, biu_bridge_pkg::BURST_INCR16, 1'b1);
    end
    close_test("preload");

    // SINGLE and undefined INCR, all legal sizes
    for (int i = 0; i < 40; i++) begin
      a = $urandom_range(ADDR_SPAN - 1, 0);
      s = $urandom_range(3, 0);
      b = $urandom_range(1, 0);
      issue(a, s, b, 1'b1);
      issue(a, s, b, 1'b0);
    end
    close_test("singles");

    kinds = '{3'd3, 3'd5, 3'd7};
    foreach (kinds[k]) begin
      for (int r = 0; r < 3; r++) begin
        a = $urandom_range(ADDR_SPAN - 1, 0);
        issue(a, 3'd3, kinds[k], 1'b1);
        issue(a, 3'd3, kinds[k], 1'b0);
      end
    end
    close_test("incr bursts");

    // Start inside the block so the addresses fold back
    kinds = '{3'd2, 3'd4, 3'd6};
    foreach (kinds[k]) begin
      for (int r = 0; r < 3; r++) begin
        n = beats_of(kinds[k]);
        a = $urandom_range(ADDR_SPAN - 1, 0) & ~(n * 8 - 1);
        a = a + $urandom_range(n - 1, 1) * 8 + $urandom_range(7, 0);
        issue(a, 3'd3, kinds[k], 1'b1);
        issue(a, 3'd3, kinds[k], 1'b0);
      end
    end
    close_test("wrap bursts");

    // Error beat, then a read of the same word
    for (int sz = 4; sz < 8; sz++) begin
      a = $urandom_range(ADDR_SPAN - 1, 0);
      issue(a, sz[2:0], $urandom_range(7, 0), $urandom_range(1, 0));
      issue(a, 3'd3, biu_bridge_pkg::BURST_SINGLE, 1'b0);
    end
    close_test("illegal sizes");

    bp_mode = 1'b1;
    for (int i = 0; i < 30; i++) begin
      a = $urandom_range(ADDR_SPAN - 1, 0);
      b = $urandom_range(7, 0);
      s = ($urandom_range(9, 0) == 0) ? 3'd4 + $urandom_range(3, 0) : $urandom_range(3, 0);
      issue(a, s, b, $urandom_range(1, 0));
    end
    close_test("backpressure");
    bp_mode = 1'b0;

    $display("summary: %0d tests, %0d clean, %0d responses, %0d errors",
             tests_run, tests_clean, rsp_seen, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+logic
logic/biu_bridge_pkg.sv
logic/skid_buffer.sv
logic/biu_cmd_decode.sv
logic/burst_addr_gen.sv
logic/spram_array.sv
logic/spram_access_stage.sv
logic/spram_bridge_top.sv
test/tb_spram_bridge.sv
